// File: design/alu_decode.sv
/* Opcode decoder and ALU
   Decodes one opcode per enabled cycle into flag load strobes and registers the result */
`timescale 1ns/1ps
`include "cpu_flags_params.svh"

module alu_decode (
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    input  logic                       i_clk_en,
    input  logic                       i_valid,
    input  logic [`CPU_DATA_W-1:0]     i_opcode,
    input  logic [`CPU_DATA_W-1:0]     i_operand,
    input  logic                       i_carry,     // Status C at issue time
    output cpu_flags_pkg::decoded_op_t o_op,
    output logic                       o_op_valid,
    output logic [`CPU_DATA_W-1:0]     o_result
);
    localparam logic [1:0] DB_ZERO    = 2'd0;
    localparam logic [1:0] DB_RESULT  = 2'd1;
    localparam logic [1:0] DB_OPERAND = 2'd2;
    localparam logic [1:0] DB_BIT     = 2'd3;

    cpu_flags_pkg::alu_op_e     alu_op;
    cpu_flags_pkg::decoded_op_t dec;
    cpu_flags_pkg::decoded_op_t op_next;
    logic [1:0]                 db_sel;
    logic                       acc_we;
    logic                       nz_load;
    logic                       cin_force;
    logic [`CPU_DATA_W-1:0]     acc;
    logic [`CPU_DATA_W-1:0]     alu_b;
    logic [`CPU_DATA_W:0]       sum;
    logic                       cin;
    logic                       ovf;
    logic [`CPU_DATA_W-1:0]     result;
    logic                       bit_zero;

    // Opcode decode
    always_comb
    begin
        dec       = '0;
        alu_op    = cpu_flags_pkg::ALU_NONE;
        db_sel    = DB_ZERO;
        acc_we    = 1'b0;
        nz_load   = 1'b0;
        cin_force = 1'b0;
        case (i_opcode)
            `OPC_ADC, `OPC_SBC:
            begin
                alu_op    = (i_opcode == `OPC_SBC) ? cpu_flags_pkg::ALU_SUB
                                                   : cpu_flags_pkg::ALU_ADD;
                db_sel    = DB_RESULT;
                nz_load   = 1'b1;
                dec.acr_c = 1'b1;
                dec.avr_v = 1'b1;
            end
            `OPC_CMP:
            begin
                alu_op    = cpu_flags_pkg::ALU_SUB;
                cin_force = 1'b1;  // Plain A minus operand
                db_sel    = DB_RESULT;
                nz_load   = 1'b1;
                dec.acr_c = 1'b1;
            end
            `OPC_AND, `OPC_ORA, `OPC_EOR, `OPC_LDA:
            begin
                case (i_opcode)
                    `OPC_AND: alu_op = cpu_flags_pkg::ALU_AND;
                    `OPC_ORA: alu_op = cpu_flags_pkg::ALU_OR;
                    `OPC_EOR: alu_op = cpu_flags_pkg::ALU_XOR;
                    default:  alu_op = cpu_flags_pkg::ALU_PASS;
                endcase
                db_sel  = DB_RESULT;
                nz_load = 1'b1;
                acc_we  = 1'b1;
            end
            `OPC_BIT:
            begin
                alu_op    = cpu_flags_pkg::ALU_AND;  // Accumulator left alone
                db_sel    = DB_BIT;
                dec.db1_z = 1'b1;
                dec.db6_v = 1'b1;
                dec.db7_n = 1'b1;
            end
            `OPC_CLC, `OPC_SEC: dec.ir5_c = 1'b1;
            `OPC_CLI, `OPC_SEI: dec.ir5_i = 1'b1;
            `OPC_CLD, `OPC_SED: dec.ir5_d = 1'b1;
            `OPC_CLV:           dec.db6_v = 1'b1;  // db stays zero
            `OPC_PLP:
            begin
                db_sel    = DB_OPERAND;
                dec.db0_c = 1'b1;
                dec.db1_z = 1'b1;
                dec.db2_i = 1'b1;
                dec.db3_d = 1'b1;
                dec.db4_b = 1'b1;
                dec.db6_v = 1'b1;
                dec.db7_n = 1'b1;
            end
            `OPC_BRK:
            begin
                db_sel    = DB_OPERAND;
                dec.db4_b = 1'b1;
            end
            default: ;  // Unknown opcodes load nothing
        endcase
        if (nz_load)
        begin
            dec.dbz_z = 1'b1;
            dec.db7_n = 1'b1;
        end
    end

    // Binary adder, decimal mode is not modelled
    assign alu_b    = (alu_op == cpu_flags_pkg::ALU_SUB) ? ~i_operand : i_operand;
    assign cin      = cin_force | i_carry;
    assign sum      = {1'b0, acc} + {1'b0, alu_b} + {{`CPU_DATA_W{1'b0}}, cin};
    assign ovf      = (acc[`CPU_DATA_W-1] == alu_b[`CPU_DATA_W-1]) &&
                      (sum[`CPU_DATA_W-1] != acc[`CPU_DATA_W-1]);
    assign bit_zero = ~|(acc & i_operand);

    always_comb
    begin
        case (alu_op)
            cpu_flags_pkg::ALU_ADD,
            cpu_flags_pkg::ALU_SUB:  result = sum[`CPU_DATA_W-1:0];
            cpu_flags_pkg::ALU_AND:  result = acc & i_operand;
            cpu_flags_pkg::ALU_OR:   result = acc | i_operand;
            cpu_flags_pkg::ALU_XOR:  result = acc ^ i_operand;
            cpu_flags_pkg::ALU_PASS: result = i_operand;
            default:                 result = acc;
        endcase
    end

    // Attach data bus and ALU status to the strobes
    always_comb
    begin
        op_next     = dec;
        op_next.acr = sum[`CPU_DATA_W];
        op_next.avr = ovf;
        op_next.ir5 = i_opcode[5];
        case (db_sel)
            DB_RESULT:  op_next.db = result;
            DB_OPERAND: op_next.db = i_operand;
            DB_BIT:
            begin
                op_next.db          = i_operand;
                op_next.db[`FLAG_Z] = bit_zero;  // Z comes from A AND operand
            end
            default:    op_next.db = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_op       <= '0;
            o_op_valid <= 1'b0;
            o_result   <= '0;
            acc        <= '0;
        end
        else if (i_clk_en)
        begin
            o_op       <= op_next;
            o_op_valid <= i_valid;
            if (i_valid && (alu_op != cpu_flags_pkg::ALU_NONE))
                o_result <= result;  // Holds across bubbles and flag-only opcodes
            if (i_valid && acc_we)
                acc <= result;
        end
    end
endmodule

// File: design/cpu_flags_pkg.sv
/* CPU flag path types
   ALU operation codes and the decoded operation word */
`include "cpu_flags_params.svh"

package cpu_flags_pkg;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,  // Adds the inverted operand
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS,
        ALU_NONE
    } alu_op_e;

    // One decoded instruction as seen by the status register
    typedef struct packed
    {
        logic [`CPU_DATA_W-1:0] db;   // Data bus value
        logic                   acr;  // ALU carry
        logic                   avr;  // ALU overflow
        logic                   ir5;  // Opcode bit 5
        logic                   db0_c;
        logic                   ir5_c;
        logic                   acr_c;
        logic                   db1_z;
        logic                   dbz_z;
        logic                   db2_i;
        logic                   ir5_i;
        logic                   db3_d;
        logic                   ir5_d;
        logic                   db4_b;
        logic                   db6_v;
        logic                   avr_v;
        logic                   db7_n;
    } decoded_op_t;

endpackage

// File: design/flag_ctrl_if.sv
/* Flag control bus
   Data byte, ALU status bits and flag load strobes */
`timescale 1ns/1ps
`include "cpu_flags_params.svh"

interface flag_ctrl_if;
    logic [`CPU_DATA_W-1:0] db;
    logic                   acr;
    logic                   avr;
    logic                   ir5;
    logic                   db0_c, ir5_c, acr_c;  // Carry loads
    logic                   db1_z, dbz_z;         // Zero loads
    logic                   db2_i, ir5_i;         // Interrupt loads
    logic                   db3_d, ir5_d;         // Decimal loads
    logic                   db4_b;
    logic                   db6_v, avr_v;         // Overflow loads
    logic                   db7_n;

    modport src (
        output db, acr, avr, ir5,
        output db0_c, ir5_c, acr_c, db1_z, dbz_z, db2_i, ir5_i,
        output db3_d, ir5_d, db4_b, db6_v, avr_v, db7_n
    );

    modport dst (
        input db, acr, avr, ir5,
        input db0_c, ir5_c, acr_c, db1_z, dbz_z, db2_i, ir5_i,
        input db3_d, ir5_d, db4_b, db6_v, avr_v, db7_n
    );
endinterface

// File: design/flag_unit.sv
/* Flag unit top level
   Decoder, operation latch and status register in a three-stage flag pipeline */
`timescale 1ns/1ps
`include "cpu_flags_params.svh"

module flag_unit (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_clk_en,
    input  logic                   i_valid,
    input  logic [`CPU_DATA_W-1:0] i_opcode,
    input  logic [`CPU_DATA_W-1:0] i_operand,
    output logic [`CPU_DATA_W-1:0] o_p,       // Status byte
    output logic [`CPU_DATA_W-1:0] o_result   // ALU result
);
    cpu_flags_pkg::decoded_op_t dec_op;
    logic                       dec_valid;

    flag_ctrl_if flag_bus ();

    alu_decode alu_decode_inst (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_clk_en   (i_clk_en),
        .i_valid    (i_valid),
        .i_opcode   (i_opcode),
        .i_operand  (i_operand),
        .i_carry    (o_p[`FLAG_C]),  // No forwarding from in-flight ops
        .o_op       (dec_op),
        .o_op_valid (dec_valid),
        .o_result   (o_result)
    );

    op_latch op_latch_inst (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_clk_en   (i_clk_en),
        .i_op       (dec_op),
        .i_op_valid (dec_valid),
        .o_bus      (flag_bus.src)
    );

    processor_status processor_status_inst (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_clk_en   (i_clk_en),
        .i_bus      (flag_bus.dst),
        .o_p        (o_p)
    );
endmodule

// File: design/op_latch.sv
/* Decoded operation latch
   One enabled-cycle stage between decoder and status register, bubbles load nothing */
`timescale 1ns/1ps

module op_latch (
    input  logic                       i_clk,
    input  logic                       i_reset_n,
    input  logic                       i_clk_en,
    input  cpu_flags_pkg::decoded_op_t i_op,
    input  logic                       i_op_valid,
    flag_ctrl_if.src                   o_bus
);
    cpu_flags_pkg::decoded_op_t op_q;
    logic                       valid_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            valid_q <= 1'b0;
        else if (i_clk_en)
            valid_q <= i_op_valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_clk_en)
            op_q <= i_op;
    end

    assign o_bus.db    = op_q.db;
    assign o_bus.acr   = op_q.acr;
    assign o_bus.avr   = op_q.avr;
    assign o_bus.ir5   = op_q.ir5;
    // Strobes only pass for a valid entry
    assign o_bus.db0_c = op_q.db0_c & valid_q;
    assign o_bus.ir5_c = op_q.ir5_c & valid_q;
    assign o_bus.acr_c = op_q.acr_c & valid_q;
    assign o_bus.db1_z = op_q.db1_z & valid_q;
    assign o_bus.dbz_z = op_q.dbz_z & valid_q;
    assign o_bus.db2_i = op_q.db2_i & valid_q;
    assign o_bus.ir5_i = op_q.ir5_i & valid_q;
    assign o_bus.db3_d = op_q.db3_d & valid_q;
    assign o_bus.ir5_d = op_q.ir5_d & valid_q;
    assign o_bus.db4_b = op_q.db4_b & valid_q;
    assign o_bus.db6_v = op_q.db6_v & valid_q;
    assign o_bus.avr_v = op_q.avr_v & valid_q;
    assign o_bus.db7_n = op_q.db7_n & valid_q;
endmodule

// File: design/processor_status.sv
/* Processor status register
   Holds C, Z, I, D, B, V and N with per-flag load priorities */
`timescale 1ns/1ps
`include "cpu_flags_params.svh"

module processor_status (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_clk_en,
    flag_ctrl_if.dst               i_bus,
    output logic [`CPU_DATA_W-1:0] o_p
);
    logic dbz;
    logic c_q;
    logic z_q;
    logic i_q;
    logic d_q;
    logic b_q;
    logic v_q;
    logic n_q;

    assign dbz = ~|i_bus.db;  // Zero test of the data bus

    // Carry, ALU carry first
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            c_q <= 1'b0;
        else if (i_clk_en)
        begin
            if (i_bus.acr_c)
                c_q <= i_bus.acr;
            else if (i_bus.ir5_c)
                c_q <= i_bus.ir5;
            else if (i_bus.db0_c)
                c_q <= i_bus.db[`FLAG_C];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            z_q <= 1'b0;
        else if (i_clk_en)
        begin
            if (i_bus.dbz_z)
                z_q <= dbz;
            else if (i_bus.db1_z)
                z_q <= i_bus.db[`FLAG_Z];
        end
    end

    // Interrupt disable and decimal mode share the same rule
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            i_q <= 1'b0;
            d_q <= 1'b0;
        end
        else if (i_clk_en)
        begin
            if (i_bus.ir5_i)
                i_q <= i_bus.ir5;
            else if (i_bus.db2_i)
                i_q <= i_bus.db[`FLAG_I];
            if (i_bus.ir5_d)
                d_q <= i_bus.ir5;
            else if (i_bus.db3_d)
                d_q <= i_bus.db[`FLAG_D];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            b_q <= 1'b0;
            v_q <= 1'b0;
            n_q <= 1'b0;
        end
        else if (i_clk_en)
        begin
            if (i_bus.db4_b)
                b_q <= i_bus.db[`FLAG_B];
            if (i_bus.avr_v)
                v_q <= i_bus.avr;           // ALU overflow wins
            else if (i_bus.db6_v)
                v_q <= i_bus.db[`FLAG_V];
            if (i_bus.db7_n)
                n_q <= i_bus.db[`FLAG_N];
        end
    end

    assign o_p[`FLAG_C] = c_q;
    assign o_p[`FLAG_Z] = z_q;
    assign o_p[`FLAG_I] = i_q;
    assign o_p[`FLAG_D] = d_q;
    assign o_p[`FLAG_B] = b_q;
    assign o_p[`FLAG_U] = 1'b1;
    assign o_p[`FLAG_V] = v_q;
    assign o_p[`FLAG_N] = n_q;
endmodule

// File: include/cpu_flags_params.svh
/* CPU flag path parameters
   Data width, status bit positions and supported opcodes */
`ifndef CPU_FLAGS_PARAMS_SVH
`define CPU_FLAGS_PARAMS_SVH

`define CPU_DATA_W 8

`define FLAG_C 0 // Carry
`define FLAG_Z 1 // Zero
`define FLAG_I 2 // Interrupt disable
`define FLAG_D 3 // Decimal mode
`define FLAG_B 4 // Break
`define FLAG_U 5 // Unused, always reads 1
`define FLAG_V 6 // Overflow
`define FLAG_N 7 // Negative

// Immediate ALU group
`define OPC_ADC 8'h69
`define OPC_SBC 8'hE9
`define OPC_AND 8'h29
`define OPC_ORA 8'h09
`define OPC_EOR 8'h49
`define OPC_CMP 8'hC9
`define OPC_LDA 8'hA9
`define OPC_BIT 8'h24 // Zero page
// Flag clear and set, bit 5 selects the value
`define OPC_CLC 8'h18
`define OPC_SEC 8'h38
`define OPC_CLI 8'h58
`define OPC_SEI 8'h78
`define OPC_CLD 8'hD8
`define OPC_SED 8'hF8
`define OPC_CLV 8'hB8
`define OPC_PLP 8'h28
`define OPC_BRK 8'h00

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the flag unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module flag_unit_tb -f tb.f \
    -o flag_unit_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/flag_unit_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation finished: PASS" sim.log \
    && { echo "Run passed"; exit 0; } \
    || { echo "Run failed, see sim.log"; exit 1; }

// File: tb.f
+incdir+include
design/cpu_flags_pkg.sv
design/flag_ctrl_if.sv
design/alu_decode.sv
design/op_latch.sv
design/processor_status.sv
design/flag_unit.sv
testbench/flag_unit_assertions.sv
testbench/flag_unit_tb.sv

// File: testbench/flag_unit_assertions.sv
/* Status register assertions
   Reset value, hold while disabled and the ALU overflow load */
`timescale 1ns/1ps
`include "cpu_flags_params.svh"

module flag_unit_assertions (
    input logic                   i_clk,
    input logic                   i_reset_n,
    input logic                   i_clk_en,
    input logic                   i_avr_v,
    input logic                   i_avr,
    input logic [`CPU_DATA_W-1:0] i_p
);
    reset_value: assert property (@(posedge i_clk) !i_reset_n |=> (i_p == 8'h20))
        else $error("Status byte is not 20 after reset");

    hold_disabled: assert property (@(posedge i_clk) disable iff (!i_reset_n)
                                    !i_clk_en |=> $stable(i_p))
        else $error("Status byte changed with clock enable low");

    overflow_load: assert property (@(posedge i_clk) disable iff (!i_reset_n)
                                    (i_clk_en && i_avr_v && i_avr) |=> i_p[`FLAG_V])
        else $error("V not set by ALU overflow");
endmodule

bind processor_status flag_unit_assertions flag_unit_assertions_inst (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_clk_en  (i_clk_en),
    .i_avr_v   (i_bus.avr_v),
    .i_avr     (i_bus.avr),
    .i_p       (o_p)
);

// File: testbench/flag_unit_tb.sv
/* Flag unit testbench
   LFSR opcode stream checked against a model of the accumulator and status byte */
`timescale 1ns/1ps
`include "cpu_flags_params.svh"

module flag_unit_tb;
    localparam int NUM_RAND       = 2000;
    localparam int NUM_DIRECTED   = 20;
    localparam int TIMEOUT_CYCLES = 2 * (NUM_RAND + NUM_DIRECTED + 8) + 100;
    localparam logic [7:0] OPCODES [17] = '{
        `OPC_ADC, `OPC_SBC, `OPC_AND, `OPC_ORA, `OPC_EOR, `OPC_CMP, `OPC_LDA, `OPC_BIT,
        `OPC_CLC, `OPC_SEC, `OPC_CLI, `OPC_SEI, `OPC_CLD, `OPC_SED, `OPC_CLV, `OPC_PLP,
        `OPC_BRK
    };

    logic       i_clk;
    logic       i_reset_n;
    logic       i_clk_en;
    logic       i_valid;
    logic [7:0] i_opcode;
    logic [7:0] i_operand;
    logic [7:0] o_p;
    logic [7:0] o_result;

    logic [7:0]  model_a;       // Accumulator
    logic [7:0]  model_p;       // Status byte
    logic [7:0]  exp_result;
    logic [7:0]  pipe_mask [2]; // Index 0 is the decode stage
    logic [7:0]  pipe_val [2];
    logic [31:0] lfsr_state = 32'he4c2;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    flag_unit flag_unit_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_clk_en  (i_clk_en),
        .i_valid   (i_valid),
        .i_opcode  (i_opcode),
        .i_operand (i_operand),
        .o_p       (o_p),
        .o_result  (o_result)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] flag_bit(input int pos);
        return 8'h01 << pos;
    endfunction

    task automatic check_value(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR at %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    // Flag effect of one instruction as mask and value, A and result update at issue
    task automatic decode_model(input logic [7:0] opc, input logic [7:0] opd,
                                output logic [7:0] mask, output logic [7:0] val);
        logic [8:0] sum;
        logic [7:0] b;
        logic [7:0] r;
        logic       nz;
        logic       has_res;
        mask    = '0;
        val     = '0;
        b       = (opc == `OPC_SBC) ? ~opd : opd;
        sum     = {1'b0, model_a} + {1'b0, b} + {8'b0, model_p[`FLAG_C]};
        r       = model_a;
        nz      = 1'b0;
        has_res = 1'b1;
        case (opc)
            `OPC_ADC, `OPC_SBC:
            begin
                r    = sum[7:0];
                mask = flag_bit(`FLAG_C) | flag_bit(`FLAG_V);
                val[`FLAG_C] = sum[8];
                val[`FLAG_V] = (model_a[7] ^ r[7]) & (b[7] ^ r[7]); // Signed overflow
                nz   = 1'b1;
            end
            `OPC_CMP:
            begin
                r    = model_a - opd;
                mask = flag_bit(`FLAG_C);
                val[`FLAG_C] = (model_a >= opd);
                nz   = 1'b1;
            end
            `OPC_AND, `OPC_ORA, `OPC_EOR, `OPC_LDA:
            begin
                case (opc)
                    `OPC_AND: r = model_a & opd;
                    `OPC_ORA: r = model_a | opd;
                    `OPC_EOR: r = model_a ^ opd;
                    default:  r = opd;
                endcase
                model_a = r;
                nz      = 1'b1;
            end
            `OPC_BIT:
            begin
                r    = model_a & opd;
                mask = flag_bit(`FLAG_N) | flag_bit(`FLAG_V) | flag_bit(`FLAG_Z);
                val  = opd;
                val[`FLAG_Z] = (r == 8'h00);
            end
            default:
            begin
                has_res = 1'b0;  // Flag-only and unknown opcodes
                case (opc)
                    `OPC_CLC, `OPC_SEC: mask = flag_bit(`FLAG_C);
                    `OPC_CLI, `OPC_SEI: mask = flag_bit(`FLAG_I);
                    `OPC_CLD, `OPC_SED: mask = flag_bit(`FLAG_D);
                    `OPC_CLV:           mask = flag_bit(`FLAG_V);
                    `OPC_PLP:           mask = ~flag_bit(`FLAG_U);
                    `OPC_BRK:           mask = flag_bit(`FLAG_B);
                    default:            mask = 8'h00;
                endcase
                val = (opc == `OPC_PLP || opc == `OPC_BRK) ? opd : '0;
                if (opc == `OPC_SEC || opc == `OPC_SEI || opc == `OPC_SED)
                    val = 8'hFF;  // Set forms
            end
        endcase
        if (nz)
        begin
            mask         = mask | flag_bit(`FLAG_N) | flag_bit(`FLAG_Z);
            val[`FLAG_N] = r[7];
            val[`FLAG_Z] = (r == 8'h00);
        end
        if (has_res)
            exp_result = r;
    endtask

    task automatic model_step(input logic valid, input logic [7:0] opc,
                              input logic [7:0] opd);
        logic [7:0] mask;
        logic [7:0] val;
        mask = '0;
        val  = '0;
        if (valid)
            decode_model(opc, opd, mask, val);  // Carry is P before this edge
        model_p      = (model_p & ~pipe_mask[1]) | (pipe_val[1] & pipe_mask[1]);
        pipe_mask[1] = pipe_mask[0];
        pipe_val[1]  = pipe_val[0];
        pipe_mask[0] = mask;
        pipe_val[0]  = val;
    endtask

    // Model the edge just taken, compare, then drive the next inputs
    task automatic run_cycle(input logic en, input logic valid,
                             input logic [7:0] opc, input logic [7:0] opd);
        @(posedge i_clk);
        #1;
        if (i_clk_en)
            model_step(i_valid, i_opcode, i_operand);
        check_value("o_p", o_p, model_p);
        check_value("o_result", o_result, exp_result);
        i_clk_en  = en;
        i_valid   = valid;
        i_opcode  = opc;
        i_operand = opd;
    endtask

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run still going after %0d clock cycles", cycle_count);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] rnd;
        logic [4:0]  idx;
        logic        en;
        logic        vld;
        logic [7:0]  opc;
        i_reset_n    = 1'b0;
        i_clk_en     = 1'b0;
        i_valid      = 1'b0;
        i_opcode     = 8'h00;
        i_operand    = 8'h00;
        model_a      = 8'h00;
        model_p      = 8'h20;
        exp_result   = 8'h00;
        pipe_mask[0] = 8'h00;
        pipe_mask[1] = 8'h00;
        pipe_val[0]  = 8'h00;
        pipe_val[1]  = 8'h00;
        repeat (4) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;
        check_value("o_p after reset", o_p, 8'h20);
        check_value("o_result after reset", o_result, 8'h00);

        // Directed start, several flag ops in flight at once
        run_cycle(1'b1, 1'b1, `OPC_SEC, 8'h00);
        run_cycle(1'b1, 1'b1, `OPC_SED, 8'h00);
        run_cycle(1'b1, 1'b1, `OPC_SEI, 8'h00);
        run_cycle(1'b1, 1'b1, `OPC_CLC, 8'h00);
        run_cycle(1'b1, 1'b0, `OPC_ADC, 8'h55);  // Bubble
        run_cycle(1'b1, 1'b1, `OPC_LDA, 8'h7F);
        run_cycle(1'b1, 1'b1, `OPC_ADC, 8'h01);
        run_cycle(1'b1, 1'b1, `OPC_SBC, 8'h80);
        run_cycle(1'b1, 1'b1, `OPC_CMP, 8'h7F);
        run_cycle(1'b1, 1'b1, `OPC_BIT, 8'hC0);
        run_cycle(1'b0, 1'b1, `OPC_LDA, 8'h00);  // Frozen
        run_cycle(1'b1, 1'b1, `OPC_PLP, 8'hFF);
        run_cycle(1'b1, 1'b1, `OPC_BRK, 8'h00);
        run_cycle(1'b1, 1'b1, `OPC_CLV, 8'h00);
        run_cycle(1'b1, 1'b1, `OPC_CLD, 8'h00);
        run_cycle(1'b1, 1'b1, `OPC_CLI, 8'h00);
        run_cycle(1'b1, 1'b1, 8'hFF, 8'hFF);     // Unknown opcode
        run_cycle(1'b1, 1'b1, `OPC_AND, 8'h0F);
        run_cycle(1'b1, 1'b1, `OPC_ORA, 8'hF0);
        run_cycle(1'b1, 1'b1, `OPC_EOR, 8'hFF);

        for (int n = 0; n < NUM_RAND; n++)
        begin
            rnd = rand_bits(5);
            en  = (rnd < 26);  // About 80% enabled
            rnd = rand_bits(4);
            vld = (rnd != 0);
            rnd = rand_bits(5);
            if (rnd >= 29)
            begin
                rnd = rand_bits(8);
                opc = rnd[7:0];
            end
            else
            begin
                idx = 5'(rnd % 17);
                opc = OPCODES[idx];
            end
            rnd = rand_bits(8);
            run_cycle(en, vld, opc, rnd[7:0]);
        end
        repeat (3) run_cycle(1'b1, 1'b0, 8'h00, 8'h00);  // Drain the pipeline

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end
endmodule
